// ==== id_cases.txt ====
# name waddr wdata inst pc ex_aluop ex_wreg ex_wd ex_wdata mem_wreg mem_wd mem_wdata
# aluop alusel wreg wd src1 src2 imm stall bflag baddr link ds, src 0 reg 1 imm 2 ex 3 mem
or_wt 1 12345678 00221825 400000 0 0 0 0 0 0 0 25 1 1 3 0 0 0 0 0 0 0 0
ori 0 0 34248001 400004 0 0 0 0 0 0 0 25 1 1 4 0 1 8001 0 0 0 0 0
lui 0 0 3c05abcd 400008 0 0 0 0 0 0 0 25 1 1 5 0 1 abcd0000 0 0 0 0 0
xori 0 0 3846ffff 40000c 0 0 0 0 0 0 0 26 1 1 6 0 1 ffff 0 0 0 0 0
nor 0 0 00643827 400010 0 0 0 0 0 0 0 27 1 1 7 0 0 0 0 0 0 0 0
sll 0 0 00024140 400014 0 0 0 0 0 0 0 7c 2 1 8 1 0 5 0 0 0 0 0
srav 0 0 016a4807 400018 0 0 0 0 0 0 0 7 2 1 9 0 0 0 0 0 0 0 0
sra 0 0 000d67c3 40001c 0 0 0 0 0 0 0 3 2 1 c 1 0 1f 0 0 0 0 0
addu 0 0 01f07021 400020 0 0 0 0 0 0 0 21 4 1 e 0 0 0 0 0 0 0 0
addi 0 0 2251fffc 400024 0 0 0 0 0 0 0 55 4 1 11 0 1 fffffffc 0 0 0 0 0
sltiu 0 0 2e938000 400028 0 0 0 0 0 0 0 2b 4 1 13 0 1 ffff8000 0 0 0 0 0
slt 0 0 02d7a82a 40002c 0 0 0 0 0 0 0 2a 4 1 15 0 0 0 0 0 0 0 0
lw 0 0 8f380010 400030 0 0 0 0 0 0 0 e3 7 1 18 0 1 0 0 0 0 0 0
sw 0 0 af7a0008 400034 0 0 0 0 0 0 0 eb 7 0 0 0 0 0 0 0 0 0 0
undef 0 0 70221802 400038 0 0 0 0 0 0 0 0 0 0 0 1 1 0 0 0 0 0 0
fwd_ex 0 0 00a61820 40003c 0 1 5 e0000005 0 0 0 20 4 1 3 2 0 0 0 0 0 0 0
fwd_mem 0 0 00a61820 400040 0 0 0 0 1 6 d0000006 20 4 1 3 0 3 0 0 0 0 0 0
fwd_both 0 0 00a61820 400044 0 1 5 e0000015 1 5 d0000015 20 4 1 3 2 0 0 0 0 0 0 0
fwd_none 0 0 00a61820 400048 0 0 5 e0000025 0 6 d0000026 20 4 1 3 0 0 0 0 0 0 0 0
load_use 0 0 00a61820 40004c e3 1 5 e0000035 0 0 0 20 4 1 3 2 0 0 1 0 0 0 0
j 0 0 08100080 400100 0 0 0 0 0 0 0 4f 6 0 0 1 1 0 0 1 400200 0 0
ds_j 0 0 01f07021 400104 0 0 0 0 0 0 0 21 4 1 e 0 0 0 0 0 0 0 1
ds_clr 0 0 00221825 400108 0 0 0 0 0 0 0 25 1 1 3 0 0 0 0 0 0 0 0
jal 0 0 0c200010 f0000200 0 0 0 0 0 0 0 50 6 1 1f 1 1 0 0 1 f0800040 f0000208 0
ds_jal 0 0 34248001 f0000204 0 0 0 0 0 0 0 25 1 1 4 0 1 8001 0 0 0 0 1
jr 9 400100 01200008 f0000208 0 0 0 0 0 0 0 8 6 0 0 0 1 0 0 1 400100 0 0
jalr 0 0 0120f809 500000 0 0 0 0 0 0 0 9 6 1 1f 0 1 0 0 1 400100 500008 1
beq_t 8 0 1100fff0 400200 0 0 0 0 0 0 0 51 6 0 0 0 0 0 0 1 4001c4 0 1
beq_nt 7 5 10e00010 400300 0 0 0 0 0 0 0 51 6 0 0 0 0 0 0 0 0 0 1
ds_clr2 0 0 3846ffff 400304 0 0 0 0 0 0 0 26 1 1 6 0 1 ffff 0 0 0 0 0

// ==== src.f ====
id_pkg.sv
fwd_if.sv
regfile.sv
inst_decoder.sv
operand_mux.sv
branch_unit.sv
id_ex_reg.sv
id_stage_top.sv
tb_id_stage.sv

// ==== Makefile ====
.PHONY: all lint clean

all:
	verilator --binary --timescale 1ns/100ps --top-module tb_id_stage -f src.f -o sim
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/100ps \
		--top-module id_stage_top -f src.f

clean:
	rm -rf obj_dir

// ==== tb_id_stage.sv ====
`timescale 1ns/100ps

module tb_id_stage;

  import id_pkg::*;

  localparam int MAX_STALL   = 16;
  localparam int CASE_FIELDS = 24;

  logic      clk;
  logic      rst_n;
  word_t     pc;
  word_t     inst;
  logic      wb_we;
  reg_addr_t wb_waddr;
  word_t     wb_wdata;
  aluop_e    ex_aluop_in;
  logic      ex_wreg_in;
  reg_addr_t ex_wd_in;
  word_t     ex_wdata_in;
  logic      mem_wreg_in;
  reg_addr_t mem_wd_in;
  word_t     mem_wdata_in;

  logic      stall;
  logic      branch_flag;
  word_t     branch_addr;
  aluop_e    ex_aluop;
  alusel_e   ex_alusel;
  word_t     ex_reg1;
  word_t     ex_reg2;
  word_t     ex_link_addr;
  word_t     ex_inst;
  reg_addr_t ex_wd;
  logic      ex_wreg;
  logic      ex_in_delayslot;

  // expected register file contents
  word_t model [NUM_REGS];

  // fields of the current case line
  string      c_name;
  reg_addr_t  c_waddr;
  word_t      c_wdata;
  word_t      c_inst;
  word_t      c_pc;
  logic [7:0] c_exop;
  logic       c_exwreg;
  reg_addr_t  c_exwd;
  word_t      c_exwdata;
  logic       c_memwreg;
  reg_addr_t  c_memwd;
  word_t      c_memwdata;
  logic [7:0] c_aluop;
  logic [2:0] c_alusel;
  logic       c_wreg;
  reg_addr_t  c_wd;
  logic [1:0] c_src1;
  logic [1:0] c_src2;
  word_t      c_imm;
  logic       c_stall;
  logic       c_bflag;
  word_t      c_baddr;
  word_t      c_link;
  logic       c_ds;

  int errors;
  int tests;
  int failed;

  always #10 clk = ~clk;

  id_stage_top uut (
    .clk_i             (clk),
    .rst_n_i           (rst_n),
    .pc_i              (pc),
    .inst_i            (inst),
    .wb_we_i           (wb_we),
    .wb_waddr_i        (wb_waddr),
    .wb_wdata_i        (wb_wdata),
    .ex_aluop_i        (ex_aluop_in),
    .ex_wreg_i         (ex_wreg_in),
    .ex_wd_i           (ex_wd_in),
    .ex_wdata_i        (ex_wdata_in),
    .mem_wreg_i        (mem_wreg_in),
    .mem_wd_i          (mem_wd_in),
    .mem_wdata_i       (mem_wdata_in),
    .stall_o           (stall),
    .branch_flag_o     (branch_flag),
    .branch_addr_o     (branch_addr),
    .ex_aluop_o        (ex_aluop),
    .ex_alusel_o       (ex_alusel),
    .ex_reg1_o         (ex_reg1),
    .ex_reg2_o         (ex_reg2),
    .ex_link_addr_o    (ex_link_addr),
    .ex_inst_o         (ex_inst),
    .ex_wd_o           (ex_wd),
    .ex_wreg_o         (ex_wreg),
    .ex_in_delayslot_o (ex_in_delayslot)
  );

  task automatic check_word(input string what, input word_t expected, input word_t actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s %s expected %h actual %h", c_name, what, expected, actual);
      errors++;
    end
  endtask

  task automatic report_test(input int start_errors);
    tests++;
    if (errors == start_errors) begin
      $display("PASS %s", c_name);
    end else begin
      $display("FAIL %s", c_name);
      failed++;
    end
  endtask

  // src codes 0 register, 1 immediate, 2 EX data, 3 MEM data
  function automatic word_t expected_operand(input logic [1:0] src, input reg_addr_t raddr);
    case (src)
      2'd0: return model[raddr];
      2'd1: return c_imm;
      2'd2: return c_exwdata;
      default: return c_memwdata;
    endcase
  endfunction

  task automatic run_case();
    int    start_errors;
    int    waits;
    word_t exp1;
    word_t exp2;
    start_errors = errors;
    pc           = c_pc;
    inst         = c_inst;
    wb_we        = (c_waddr != ZERO_REG);
    wb_waddr     = c_waddr;
    wb_wdata     = c_wdata;
    ex_aluop_in  = aluop_e'(c_exop);
    ex_wreg_in   = c_exwreg;
    ex_wd_in     = c_exwd;
    ex_wdata_in  = c_exwdata;
    mem_wreg_in  = c_memwreg;
    mem_wd_in    = c_memwd;
    mem_wdata_in = c_memwdata;
    // same-cycle writeback is visible to decode
    if (c_waddr != ZERO_REG) begin
      model[c_waddr] = c_wdata;
    end
    exp1 = expected_operand(c_src1, c_inst[25:21]);
    exp2 = expected_operand(c_src2, c_inst[20:16]);
    #1;
    check_word("stall", 32'(c_stall), 32'(stall));
    check_word("branch_flag", 32'(c_bflag), 32'(branch_flag));
    check_word("branch_addr", c_baddr, branch_addr);
    if (c_stall) begin
      @(posedge clk);
      @(negedge clk);
      wb_we = 1'b0;
      check_word("bubble wreg", 32'h0, 32'(ex_wreg));
      check_word("bubble aluop", 32'(ALU_NOP), 32'(ex_aluop));
      // load leaves EX, forwarding now possible
      ex_aluop_in = ALU_NOP;
      waits = 0;
      #1;
      while (stall && waits < MAX_STALL) begin
        @(posedge clk);
        @(negedge clk);
        #1;
        waits++;
      end
      if (stall) begin
        $display("stall_o still high %0d cycles after the load left EX in %s", waits, c_name);
        errors++;
      end
    end
    @(posedge clk);
    @(negedge clk);
    wb_we = 1'b0;
    check_word("aluop", 32'(c_aluop), 32'(ex_aluop));
    check_word("alusel", 32'(c_alusel), 32'(ex_alusel));
    check_word("wreg", 32'(c_wreg), 32'(ex_wreg));
    if (c_wreg) begin
      check_word("wd", 32'(c_wd), 32'(ex_wd));
    end
    check_word("reg1", exp1, ex_reg1);
    check_word("reg2", exp2, ex_reg2);
    check_word("link_addr", c_link, ex_link_addr);
    check_word("inst", c_inst, ex_inst);
    check_word("in_delayslot", 32'(c_ds), 32'(ex_in_delayslot));
    report_test(start_errors);
  endtask

  initial begin
    int          fd;
    int          n;
    int          start_errors;
    string       line;
    clk          = 1'b0;
    rst_n        = 1'b0;
    pc           = '0;
    inst         = '0;
    wb_we        = 1'b0;
    wb_waddr     = '0;
    wb_wdata     = '0;
    ex_aluop_in  = ALU_NOP;
    ex_wreg_in   = 1'b0;
    ex_wd_in     = '0;
    ex_wdata_in  = '0;
    mem_wreg_in  = 1'b0;
    mem_wd_in    = '0;
    mem_wdata_in = '0;
    errors       = 0;
    tests        = 0;
    failed       = 0;
    void'($urandom(32'h7851d70a));

    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // no rising edge since release, ID/EX still holds its reset values
    c_name = "reset";
    start_errors = errors;
    check_word("wreg", 32'h0, 32'(ex_wreg));
    check_word("in_delayslot", 32'h0, 32'(ex_in_delayslot));
    check_word("branch_flag", 32'h0, 32'(branch_flag));
    check_word("aluop", 32'(ALU_NOP), 32'(ex_aluop));
    report_test(start_errors);
    @(negedge clk);

    // random register contents through the writeback port
    model[ZERO_REG] = '0;
    for (int i = 1; i < NUM_REGS; i++) begin
      wb_we    = 1'b1;
      wb_waddr = reg_addr_t'(i);
      wb_wdata = $urandom();
      model[wb_waddr] = wb_wdata;
      @(negedge clk);
    end
    wb_we = 1'b0;

    fd = $fopen("id_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open id_cases.txt");
      errors++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.getc(0) == "#") begin
          continue;
        end
        n = $sscanf(line,
          "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
          c_name, c_waddr, c_wdata, c_inst, c_pc, c_exop, c_exwreg, c_exwd, c_exwdata,
          c_memwreg, c_memwd, c_memwdata, c_aluop, c_alusel, c_wreg, c_wd, c_src1, c_src2,
          c_imm, c_stall, c_bflag, c_baddr, c_link, c_ds);
        if (n == CASE_FIELDS) begin
          run_case();
        end else if (n > 0) begin
          $display("malformed line in id_cases.txt: %s", line);
          errors++;
        end
      end
      $fclose(fd);
    end
    if (tests < 2) begin
      $display("no test cases were run from id_cases.txt");
      errors++;
    end

    $display("tests %0d, passed %0d, failed %0d", tests, tests - failed, failed);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== id_stage_top.sv ====
`timescale 1ns/100ps

module id_stage_top (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  id_pkg::word_t     pc_i,
  input  id_pkg::word_t     inst_i,
  input  logic              wb_we_i,
  input  id_pkg::reg_addr_t wb_waddr_i,
  input  id_pkg::word_t     wb_wdata_i,
  input  id_pkg::aluop_e    ex_aluop_i,
  input  logic              ex_wreg_i,
  input  id_pkg::reg_addr_t ex_wd_i,
  input  id_pkg::word_t     ex_wdata_i,
  input  logic              mem_wreg_i,
  input  id_pkg::reg_addr_t mem_wd_i,
  input  id_pkg::word_t     mem_wdata_i,
  output logic              stall_o,
  output logic              branch_flag_o,
  output id_pkg::word_t     branch_addr_o,
  output id_pkg::aluop_e    ex_aluop_o,
  output id_pkg::alusel_e   ex_alusel_o,
  output id_pkg::word_t     ex_reg1_o,
  output id_pkg::word_t     ex_reg2_o,
  output id_pkg::word_t     ex_link_addr_o,
  output id_pkg::word_t     ex_inst_o,
  output id_pkg::reg_addr_t ex_wd_o,
  output logic              ex_wreg_o,
  output logic              ex_in_delayslot_o
);

  import id_pkg::*;

  dec_ctrl_t ctrl;
  reg_addr_t raddr1;
  reg_addr_t raddr2;
  word_t     rdata1;
  word_t     rdata2;
  word_t     reg1;
  word_t     reg2;
  word_t     link_addr;
  logic      stall1;
  logic      stall2;
  logic      branch_raw;

  fwd_if fwd ();

  assign fwd.ex_wreg    = ex_wreg_i;
  assign fwd.ex_wd      = ex_wd_i;
  assign fwd.ex_wdata   = ex_wdata_i;
  assign fwd.ex_is_load = (ex_aluop_i == ALU_LW);
  assign fwd.mem_wreg   = mem_wreg_i;
  assign fwd.mem_wd     = mem_wd_i;
  assign fwd.mem_wdata  = mem_wdata_i;

  regfile u_regfile (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .we_i     (wb_we_i),
    .waddr_i  (wb_waddr_i),
    .wdata_i  (wb_wdata_i),
    .raddr1_i (raddr1),
    .raddr2_i (raddr2),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2)
  );

  inst_decoder u_decoder (
    .inst_i   (inst_i),
    .ctrl_o   (ctrl),
    .raddr1_o (raddr1),
    .raddr2_o (raddr2)
  );

  operand_mux u_op1 (
    .fwd       (fwd),
    .raddr_i   (raddr1),
    .read_i    (ctrl.reg1_read),
    .rdata_i   (rdata1),
    .imm_i     (ctrl.imm),
    .operand_o (reg1),
    .stall_o   (stall1)
  );

  operand_mux u_op2 (
    .fwd       (fwd),
    .raddr_i   (raddr2),
    .read_i    (ctrl.reg2_read),
    .rdata_i   (rdata2),
    .imm_i     (ctrl.imm),
    .operand_o (reg2),
    .stall_o   (stall2)
  );

  assign stall_o = stall1 | stall2;

  branch_unit u_branch (
    .pc_i          (pc_i),
    .inst_i        (inst_i),
    .reg1_i        (reg1),
    .reg2_i        (reg2),
    .kind_i        (ctrl.br_kind),
    .branch_flag_o (branch_raw),
    .branch_addr_o (branch_addr_o),
    .link_addr_o   (link_addr)
  );

  // operands are not valid while stalled, so no redirect
  assign branch_flag_o = branch_raw & ~stall_o;

  id_ex_reg u_id_ex (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .stall_i           (stall_o),
    .ctrl_i            (ctrl),
    .reg1_i            (reg1),
    .reg2_i            (reg2),
    .link_i            (link_addr),
    .inst_i            (inst_i),
    .taken_i           (branch_flag_o),
    .ex_aluop_o        (ex_aluop_o),
    .ex_alusel_o       (ex_alusel_o),
    .ex_reg1_o         (ex_reg1_o),
    .ex_reg2_o         (ex_reg2_o),
    .ex_link_addr_o    (ex_link_addr_o),
    .ex_inst_o         (ex_inst_o),
    .ex_wd_o           (ex_wd_o),
    .ex_wreg_o         (ex_wreg_o),
    .ex_in_delayslot_o (ex_in_delayslot_o)
  );

endmodule

// ==== id_ex_reg.sv ====
`timescale 1ns/100ps

module id_ex_reg (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              stall_i,
  input  id_pkg::dec_ctrl_t ctrl_i,
  input  id_pkg::word_t     reg1_i,
  input  id_pkg::word_t     reg2_i,
  input  id_pkg::word_t     link_i,
  input  id_pkg::word_t     inst_i,
  input  logic              taken_i,
  output id_pkg::aluop_e    ex_aluop_o,
  output id_pkg::alusel_e   ex_alusel_o,
  output id_pkg::word_t     ex_reg1_o,
  output id_pkg::word_t     ex_reg2_o,
  output id_pkg::word_t     ex_link_addr_o,
  output id_pkg::word_t     ex_inst_o,
  output id_pkg::reg_addr_t ex_wd_o,
  output logic              ex_wreg_o,
  output logic              ex_in_delayslot_o
);

  import id_pkg::*;

  // next accepted instruction sits in a delay slot
  logic ds_pending;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ex_aluop_o        <= ALU_NOP;
      ex_alusel_o       <= SEL_NOP;
      ex_reg1_o         <= '0;
      ex_reg2_o         <= '0;
      ex_link_addr_o    <= '0;
      ex_inst_o         <= '0;
      ex_wd_o           <= '0;
      ex_wreg_o         <= 1'b0;
      ex_in_delayslot_o <= 1'b0;
      ds_pending        <= 1'b0;
    end else if (stall_i) begin
      // bubble, ds_pending waits for the held instruction
      ex_aluop_o        <= ALU_NOP;
      ex_alusel_o       <= SEL_NOP;
      ex_reg1_o         <= '0;
      ex_reg2_o         <= '0;
      ex_link_addr_o    <= '0;
      ex_inst_o         <= '0;
      ex_wd_o           <= '0;
      ex_wreg_o         <= 1'b0;
      ex_in_delayslot_o <= 1'b0;
    end else begin
      ex_aluop_o        <= ctrl_i.aluop;
      ex_alusel_o       <= ctrl_i.alusel;
      ex_reg1_o         <= reg1_i;
      ex_reg2_o         <= reg2_i;
      ex_link_addr_o    <= link_i;
      ex_inst_o         <= inst_i;
      ex_wd_o           <= ctrl_i.wd;
      ex_wreg_o         <= ctrl_i.wreg;
      ex_in_delayslot_o <= ds_pending;
      ds_pending        <= taken_i;
    end
  end

endmodule

// ==== branch_unit.sv ====
`timescale 1ns/100ps

module branch_unit (
  input  id_pkg::word_t    pc_i,
  input  id_pkg::word_t    inst_i,
  input  id_pkg::word_t    reg1_i,
  input  id_pkg::word_t    reg2_i,
  input  id_pkg::br_kind_e kind_i,
  output logic             branch_flag_o,
  output id_pkg::word_t    branch_addr_o,
  output id_pkg::word_t    link_addr_o
);

  import id_pkg::*;

  word_t pc_plus_4;
  word_t pc_plus_8;
  word_t jump_target;
  word_t beq_target;

  assign pc_plus_4 = pc_i + PC_STEP;
  assign pc_plus_8 = pc_plus_4 + PC_STEP;

  // region of the delay slot keeps its top nibble
  assign jump_target = {pc_plus_4[31:28], inst_i[25:0], 2'b00};
  assign beq_target  = pc_plus_4 + {{14{inst_i[15]}}, inst_i[15:0], 2'b00};

  always_comb begin
    branch_flag_o = 1'b0;
    branch_addr_o = '0;
    link_addr_o   = '0;
    case (kind_i)
      BR_J, BR_JAL: begin
        branch_flag_o = 1'b1;
        branch_addr_o = jump_target;
      end
      BR_JR, BR_JALR: begin
        branch_flag_o = 1'b1;
        branch_addr_o = reg1_i;
      end
      BR_BEQ: begin
        if (reg1_i == reg2_i) begin
          branch_flag_o = 1'b1;
          branch_addr_o = beq_target;
        end
      end
      default: begin
      end
    endcase
    // return past the delay slot
    if ((kind_i == BR_JAL) || (kind_i == BR_JALR)) begin
      link_addr_o = pc_plus_8;
    end
  end

endmodule

// ==== operand_mux.sv ====
`timescale 1ns/100ps

module operand_mux (
  fwd_if.sink               fwd,
  input  id_pkg::reg_addr_t raddr_i,
  input  logic              read_i,
  input  id_pkg::word_t     rdata_i,
  input  id_pkg::word_t     imm_i,
  output id_pkg::word_t     operand_o,
  output logic              stall_o
);

  import id_pkg::*;

  logic ex_match;
  logic mem_match;

  // r0 is never forwarded, it always reads zero
  assign ex_match  = (fwd.ex_wd == raddr_i) && (raddr_i != ZERO_REG);
  assign mem_match = (fwd.mem_wd == raddr_i) && (raddr_i != ZERO_REG);

  always_comb begin
    stall_o   = 1'b0;
    operand_o = rdata_i;
    if (!read_i) begin
      operand_o = imm_i;
    end else if (fwd.ex_is_load && ex_match) begin
      // load data only exists after MEM
      stall_o = 1'b1;
    end else if (fwd.ex_wreg && ex_match) begin
      operand_o = fwd.ex_wdata;
    end else if (fwd.mem_wreg && mem_match) begin
      operand_o = fwd.mem_wdata;
    end
  end

endmodule

// ==== inst_decoder.sv ====
`timescale 1ns/100ps

module inst_decoder (
  input  id_pkg::word_t     inst_i,
  output id_pkg::dec_ctrl_t ctrl_o,
  output id_pkg::reg_addr_t raddr1_o,
  output id_pkg::reg_addr_t raddr2_o
);

  import id_pkg::*;

  opcode_e     op;
  funct_e      funct;
  reg_addr_t   rs;
  reg_addr_t   rt;
  reg_addr_t   rd;
  logic [4:0]  shamt;
  logic [15:0] imm16;
  word_t       imm_zext;
  word_t       imm_sext;
  aluop_e      r_aluop;
  logic        shift_imm;
  logic        r_valid;

  assign op    = opcode_e'(inst_i[31:26]);
  assign rs    = inst_i[25:21];
  assign rt    = inst_i[20:16];
  assign rd    = inst_i[15:11];
  assign shamt = inst_i[10:6];
  assign funct = funct_e'(inst_i[5:0]);
  assign imm16 = inst_i[15:0];

  assign imm_zext = {16'h0000, imm16};
  assign imm_sext = {{16{imm16[15]}}, imm16};

  assign raddr1_o = rs;
  assign raddr2_o = rt;

  function automatic aluop_e funct_aluop(funct_e f);
    case (f)
      FN_SLL:  return ALU_SLL;
      FN_SRL:  return ALU_SRL;
      FN_SRA:  return ALU_SRA;
      FN_SLLV: return ALU_SLLV;
      FN_SRLV: return ALU_SRLV;
      FN_SRAV: return ALU_SRAV;
      FN_JR:   return ALU_JR;
      FN_JALR: return ALU_JALR;
      FN_ADD:  return ALU_ADD;
      FN_ADDU: return ALU_ADDU;
      FN_SUB:  return ALU_SUB;
      FN_SUBU: return ALU_SUBU;
      FN_AND:  return ALU_AND;
      FN_OR:   return ALU_OR;
      FN_XOR:  return ALU_XOR;
      FN_NOR:  return ALU_NOR;
      FN_SLT:  return ALU_SLT;
      FN_SLTU: return ALU_SLTU;
      default: return ALU_NOP;
    endcase
  endfunction

  assign r_aluop   = funct_aluop(funct);
  assign shift_imm = (funct == FN_SLL) || (funct == FN_SRL) || (funct == FN_SRA);
  // immediate shifts need rs zero, the other register forms need shamt zero
  assign r_valid   = (r_aluop != ALU_NOP) && (shift_imm ? (rs == ZERO_REG) : (shamt == 5'd0));

  always_comb begin
    ctrl_o.aluop     = ALU_NOP;
    ctrl_o.alusel    = SEL_NOP;
    ctrl_o.wreg      = 1'b0;
    ctrl_o.wd        = rd;
    ctrl_o.reg1_read = 1'b0;
    ctrl_o.reg2_read = 1'b0;
    ctrl_o.br_kind   = BR_NONE;
    ctrl_o.imm       = '0;

    // all-zero word is the canonical nop
    if (inst_i != '0) begin
      case (op)
        OP_SPECIAL: begin
          if (r_valid) begin
            ctrl_o.aluop     = r_aluop;
            ctrl_o.wreg      = (funct != FN_JR);
            ctrl_o.reg1_read = !shift_imm;
            ctrl_o.reg2_read = (funct != FN_JR) && (funct != FN_JALR);
            if (shift_imm) begin
              ctrl_o.imm = {27'd0, shamt};
            end
            case (funct)
              FN_AND, FN_OR, FN_XOR, FN_NOR: ctrl_o.alusel = SEL_LOGIC;
              FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV: ctrl_o.alusel = SEL_SHIFT;
              FN_JR: begin
                ctrl_o.alusel  = SEL_JUMP_BRANCH;
                ctrl_o.br_kind = BR_JR;
              end
              FN_JALR: begin
                ctrl_o.alusel  = SEL_JUMP_BRANCH;
                ctrl_o.br_kind = BR_JALR;
              end
              default: ctrl_o.alusel = SEL_ARITH;
            endcase
          end
        end
        OP_ORI, OP_ANDI, OP_XORI, OP_LUI, OP_SLTI, OP_SLTIU, OP_ADDI, OP_ADDIU, OP_LW: begin
          ctrl_o.wreg      = 1'b1;
          ctrl_o.wd        = rt;
          ctrl_o.reg1_read = 1'b1;
          case (op)
            OP_ORI:   ctrl_o.aluop = ALU_OR;
            OP_ANDI:  ctrl_o.aluop = ALU_AND;
            OP_XORI:  ctrl_o.aluop = ALU_XOR;
            OP_LUI:   ctrl_o.aluop = ALU_OR;
            OP_SLTI:  ctrl_o.aluop = ALU_SLT;
            OP_SLTIU: ctrl_o.aluop = ALU_SLTU;
            OP_ADDI:  ctrl_o.aluop = ALU_ADDI;
            OP_ADDIU: ctrl_o.aluop = ALU_ADDIU;
            default:  ctrl_o.aluop = ALU_LW;
          endcase
          case (op)
            OP_ORI, OP_ANDI, OP_XORI: begin
              ctrl_o.alusel = SEL_LOGIC;
              ctrl_o.imm    = imm_zext;
            end
            OP_LUI: begin
              ctrl_o.alusel = SEL_LOGIC;
              ctrl_o.imm    = {imm16, 16'h0000};
            end
            OP_LW: ctrl_o.alusel = SEL_LOAD_STORE;
            default: begin
              ctrl_o.alusel = SEL_ARITH;
              ctrl_o.imm    = imm_sext;
            end
          endcase
        end
        OP_J: begin
          ctrl_o.aluop   = ALU_J;
          ctrl_o.alusel  = SEL_JUMP_BRANCH;
          ctrl_o.br_kind = BR_J;
        end
        OP_JAL: begin
          ctrl_o.aluop   = ALU_JAL;
          ctrl_o.alusel  = SEL_JUMP_BRANCH;
          ctrl_o.wreg    = 1'b1;
          ctrl_o.wd      = LINK_REG;
          ctrl_o.br_kind = BR_JAL;
        end
        OP_BEQ: begin
          ctrl_o.aluop     = ALU_BEQ;
          ctrl_o.alusel    = SEL_JUMP_BRANCH;
          ctrl_o.reg1_read = 1'b1;
          ctrl_o.reg2_read = 1'b1;
          ctrl_o.br_kind   = BR_BEQ;
        end
        OP_SW: begin
          ctrl_o.aluop     = ALU_SW;
          ctrl_o.alusel    = SEL_LOAD_STORE;
          ctrl_o.reg1_read = 1'b1;
          ctrl_o.reg2_read = 1'b1;
        end
        default: begin
        end
      endcase
    end
  end

endmodule

// ==== regfile.sv ====
`timescale 1ns/100ps

module regfile (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              we_i,
  input  id_pkg::reg_addr_t waddr_i,
  input  id_pkg::word_t     wdata_i,
  input  id_pkg::reg_addr_t raddr1_i,
  input  id_pkg::reg_addr_t raddr2_i,
  output id_pkg::word_t     rdata1_o,
  output id_pkg::word_t     rdata2_o
);

  import id_pkg::*;

  word_t regs [NUM_REGS];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (waddr_i != ZERO_REG)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // write-through so a same-cycle writeback is seen by decode
  function automatic word_t read_port(reg_addr_t raddr);
    if (raddr == ZERO_REG) begin
      return '0;
    end else if (we_i && (waddr_i == raddr)) begin
      return wdata_i;
    end
    return regs[raddr];
  endfunction

  always_comb begin
    rdata1_o = read_port(raddr1_i);
    rdata2_o = read_port(raddr2_i);
  end

endmodule

// ==== fwd_if.sv ====
`timescale 1ns/100ps

interface fwd_if;

  import id_pkg::*;

  // producer in EX
  logic      ex_wreg;
  reg_addr_t ex_wd;
  word_t     ex_wdata;
  logic      ex_is_load;

  // producer in MEM
  logic      mem_wreg;
  reg_addr_t mem_wd;
  word_t     mem_wdata;

  modport source (
    output ex_wreg, ex_wd, ex_wdata, ex_is_load,
    output mem_wreg, mem_wd, mem_wdata
  );

  modport sink (
    input ex_wreg, ex_wd, ex_wdata, ex_is_load,
    input mem_wreg, mem_wd, mem_wdata
  );

endinterface

// ==== id_pkg.sv ====
package id_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;

  localparam int        NUM_REGS = 32;
  localparam reg_addr_t LINK_REG = 5'd31;
  localparam reg_addr_t ZERO_REG = 5'd0;
  localparam word_t     PC_STEP  = 32'd4;

  // primary opcode, inst[31:26]
  typedef enum logic [5:0] {
    OP_SPECIAL = 6'b000000,
    OP_J       = 6'b000010,
    OP_JAL     = 6'b000011,
    OP_BEQ     = 6'b000100,
    OP_ADDI    = 6'b001000,
    OP_ADDIU   = 6'b001001,
    OP_SLTI    = 6'b001010,
    OP_SLTIU   = 6'b001011,
    OP_ANDI    = 6'b001100,
    OP_ORI     = 6'b001101,
    OP_XORI    = 6'b001110,
    OP_LUI     = 6'b001111,
    OP_LW      = 6'b100011,
    OP_SW      = 6'b101011
  } opcode_e;

  // funct field of SPECIAL, inst[5:0]
  typedef enum logic [5:0] {
    FN_SLL  = 6'b000000,
    FN_SRL  = 6'b000010,
    FN_SRA  = 6'b000011,
    FN_SLLV = 6'b000100,
    FN_SRLV = 6'b000110,
    FN_SRAV = 6'b000111,
    FN_JR   = 6'b001000,
    FN_JALR = 6'b001001,
    FN_ADD  = 6'b100000,
    FN_ADDU = 6'b100001,
    FN_SUB  = 6'b100010,
    FN_SUBU = 6'b100011,
    FN_AND  = 6'b100100,
    FN_OR   = 6'b100101,
    FN_XOR  = 6'b100110,
    FN_NOR  = 6'b100111,
    FN_SLT  = 6'b101010,
    FN_SLTU = 6'b101011
  } funct_e;

  typedef enum logic [7:0] {
    ALU_NOP   = 8'b00000000,
    ALU_SRL   = 8'b00000010,
    ALU_SRA   = 8'b00000011,
    ALU_SLLV  = 8'b00000100,
    ALU_SRLV  = 8'b00000110,
    ALU_SRAV  = 8'b00000111,
    ALU_JR    = 8'b00001000,
    ALU_JALR  = 8'b00001001,
    ALU_ADD   = 8'b00100000,
    ALU_ADDU  = 8'b00100001,
    ALU_SUB   = 8'b00100010,
    ALU_SUBU  = 8'b00100011,
    ALU_AND   = 8'b00100100,
    ALU_OR    = 8'b00100101,
    ALU_XOR   = 8'b00100110,
    ALU_NOR   = 8'b00100111,
    ALU_SLT   = 8'b00101010,
    ALU_SLTU  = 8'b00101011,
    ALU_J     = 8'b01001111,
    ALU_JAL   = 8'b01010000,
    ALU_BEQ   = 8'b01010001,
    ALU_ADDI  = 8'b01010101,
    ALU_ADDIU = 8'b01010110,
    ALU_SLL   = 8'b01111100,
    ALU_LW    = 8'b11100011,
    ALU_SW    = 8'b11101011
  } aluop_e;

  typedef enum logic [2:0] {
    SEL_NOP         = 3'b000,
    SEL_LOGIC       = 3'b001,
    SEL_SHIFT       = 3'b010,
    SEL_ARITH       = 3'b100,
    SEL_JUMP_BRANCH = 3'b110,
    SEL_LOAD_STORE  = 3'b111
  } alusel_e;

  typedef enum logic [2:0] {
    BR_NONE,
    BR_J,
    BR_JAL,
    BR_JR,
    BR_JALR,
    BR_BEQ
  } br_kind_e;

  typedef struct packed {
    aluop_e    aluop;
    alusel_e   alusel;
    logic      wreg;
    reg_addr_t wd;
    logic      reg1_read;
    logic      reg2_read;
    br_kind_e  br_kind;
    word_t     imm;
  } dec_ctrl_t;

endpackage
